// File: Bender.yml
package:
  name: hci_lite

sources:
  - hw/hci_pkg.sv
  - hw/hci_queue.sv
  - hw/hci_addr_ctrl.sv
  - hw/hci_csr.sv
  - hw/hci_top.sv
  - target: test
    files:
      - verification/hci_top_props.sv
      - verification/tb_hci_top.sv

// File: hci_lite.f
hw/hci_pkg.sv
hw/hci_queue.sv
hw/hci_addr_ctrl.sv
hw/hci_csr.sv
hw/hci_top.sv
verification/hci_top_props.sv
verification/tb_hci_top.sv

// File: hw/hci_addr_ctrl.sv
/* Dynamic address registers */
`timescale 1ns/1ps

module hci_addr_ctrl (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  hci_pkg::addr_evt_t addr_evt_i,
  output hci_pkg::dyn_addr_t dev_addr_o,
  output hci_pkg::dyn_addr_t virt_addr_o
);

  import hci_pkg::*;

  dyn_addr_t dev_q, virt_q;
  dyn_addr_t dasa_val;
  logic dasa_evt;

  assign dasa_evt = addr_evt_i.set_dasa | addr_evt_i.rstdaa;

  // RSTDAA wipes the selected register
  always_comb begin
    if (addr_evt_i.rstdaa) begin
      dasa_val = '0;
    end else begin
      dasa_val = '{valid: 1'b1, addr: addr_evt_i.dasa};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dev_q <= '0;
      virt_q <= '0;
    end else if (dasa_evt) begin  // Takes precedence over SETNEWDA
      if (addr_evt_i.dasa_virtual) begin
        virt_q <= dasa_val;
      end else begin
        dev_q <= dasa_val;
      end
    end else begin
      if (addr_evt_i.set_newda) begin
        dev_q <= '{valid: 1'b1, addr: addr_evt_i.newda};
      end
      if (addr_evt_i.set_newda_virtual) begin
        virt_q <= '{valid: 1'b1, addr: addr_evt_i.newda};
      end
    end
  end

  assign dev_addr_o = dev_q;
  assign virt_addr_o = virt_q;

endmodule : hci_addr_ctrl

// File: hw/hci_csr.sv
/* HCI register block */
`timescale 1ns/1ps

module hci_csr (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  hci_pkg::csr_req_t            csr_req_i,
  output hci_pkg::csr_rsp_t            csr_rsp_o,
  input  hci_pkg::queue_stat_t         cmd_stat_i,
  input  hci_pkg::queue_stat_t         resp_stat_i,
  input  logic [hci_pkg::CsrDataW-1:0] resp_data_i,
  input  logic                         cmd_flush_done_i,
  input  logic                         resp_flush_done_i,
  input  hci_pkg::dyn_addr_t           dev_addr_i,
  input  hci_pkg::dyn_addr_t           virt_addr_i,
  output logic                         cmd_push_o,
  output logic [hci_pkg::CmdDataW-1:0] cmd_data_o,
  output logic                         resp_pop_o,
  output logic                         cmd_flush_o,
  output logic                         resp_flush_o,
  output logic [hci_pkg::ThldW-1:0]    cmd_thld_o,
  output logic [hci_pkg::ThldW-1:0]    resp_thld_o
);

  import hci_pkg::*;

  logic rd_req, wr_req;
  logic addr_hit;
  logic rd_err_d, wr_err_d;
  logic [CsrDataW-1:0] rd_data_d, rd_data_q;
  logic rd_ack_q, rd_err_q, wr_ack_q, wr_err_q;
  logic cmd_wr, cmd_rst_q, resp_rst_q;
  logic cmd_phase_q;  // Low DWORD held
  logic [CsrDataW-1:0] cmd_lo_q;
  logic [ThldW-1:0] cmd_thld_q, resp_thld_q;

  assign rd_req = csr_req_i.req && !csr_req_i.is_wr;
  assign wr_req = csr_req_i.req && csr_req_i.is_wr;
  assign cmd_wr = wr_req && (csr_req_i.addr == REG_COMMAND_PORT);

  // Second DWORD completes the command
  assign cmd_push_o = cmd_wr && cmd_phase_q && !cmd_stat_i.full;
  assign cmd_data_o = {csr_req_i.wdata, cmd_lo_q};
  assign resp_pop_o = rd_req && (csr_req_i.addr == REG_RESPONSE_PORT) && !resp_stat_i.empty;

  always_comb begin
    addr_hit = 1'b1;
    rd_data_d = '0;
    unique case (csr_req_i.addr)
      REG_RESET_CONTROL: begin
        rd_data_d[CMD_QUEUE_RST_BIT] = cmd_rst_q;
        rd_data_d[RESP_QUEUE_RST_BIT] = resp_rst_q;
      end
      REG_COMMAND_PORT: ;  // Write only
      REG_RESPONSE_PORT: rd_data_d = resp_stat_i.empty ? '0 : resp_data_i;
      REG_QUEUE_THLD_CTRL: begin
        rd_data_d[CMD_THLD_LSB +: ThldW] = cmd_thld_q;
        rd_data_d[RESP_THLD_LSB +: ThldW] = resp_thld_q;
      end
      REG_QUEUE_STATUS: begin
        rd_data_d[STAT_CMD_LSB +: 3] = {cmd_stat_i.trig, cmd_stat_i.full, cmd_stat_i.empty};
        rd_data_d[STAT_RESP_LSB +: 3] = {resp_stat_i.trig, resp_stat_i.full, resp_stat_i.empty};
      end
      REG_DEVICE_ADDR: begin
        rd_data_d[ADDR_VALID_BIT] = dev_addr_i.valid;
        rd_data_d[ADDR_LSB +: DynAddrW] = dev_addr_i.addr;
      end
      REG_VIRT_DEVICE_ADDR: begin
        rd_data_d[ADDR_VALID_BIT] = virt_addr_i.valid;
        rd_data_d[ADDR_LSB +: DynAddrW] = virt_addr_i.addr;
      end
      default: addr_hit = 1'b0;
    endcase
  end

  assign rd_err_d = !addr_hit || ((csr_req_i.addr == REG_RESPONSE_PORT) && resp_stat_i.empty);
  assign wr_err_d = !addr_hit || (cmd_wr && cmd_phase_q && cmd_stat_i.full);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ack_q <= 1'b0;
      rd_err_q <= 1'b0;
      wr_ack_q <= 1'b0;
      wr_err_q <= 1'b0;
    end else begin
      rd_ack_q <= rd_req;
      rd_err_q <= rd_req && rd_err_d;
      wr_ack_q <= wr_req;
      wr_err_q <= wr_req && wr_err_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_req) begin
      rd_data_q <= rd_data_d;  // Zero on a miss
    end
  end

  assign csr_rsp_o = '{
    rd_ack: rd_ack_q,
    rd_err: rd_err_q,
    wr_ack: wr_ack_q,
    wr_err: wr_err_q,
    rd_data: rd_ack_q ? rd_data_q : '0
  };

  // Command DWORD phase, dropped command restarts at low DWORD
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmd_phase_q <= 1'b0;
    end else if (cmd_wr) begin
      cmd_phase_q <= !cmd_phase_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_wr && !cmd_phase_q) begin
      cmd_lo_q <= csr_req_i.wdata;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmd_thld_q <= '0;
      resp_thld_q <= '0;
    end else if (wr_req && (csr_req_i.addr == REG_QUEUE_THLD_CTRL)) begin
      cmd_thld_q <= csr_req_i.wdata[CMD_THLD_LSB +: ThldW];
      resp_thld_q <= csr_req_i.wdata[RESP_THLD_LSB +: ThldW];
    end
  end

  // Self-clearing once the queue reports the flush
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmd_rst_q <= 1'b0;
      resp_rst_q <= 1'b0;
    end else begin
      if (cmd_flush_done_i) begin
        cmd_rst_q <= 1'b0;
      end else if (wr_req && (csr_req_i.addr == REG_RESET_CONTROL)) begin
        cmd_rst_q <= cmd_rst_q | csr_req_i.wdata[CMD_QUEUE_RST_BIT];
      end
      if (resp_flush_done_i) begin
        resp_rst_q <= 1'b0;
      end else if (wr_req && (csr_req_i.addr == REG_RESET_CONTROL)) begin
        resp_rst_q <= resp_rst_q | csr_req_i.wdata[RESP_QUEUE_RST_BIT];
      end
    end
  end

  assign cmd_flush_o = cmd_rst_q;
  assign resp_flush_o = resp_rst_q;
  assign cmd_thld_o = cmd_thld_q;
  assign resp_thld_o = resp_thld_q;

endmodule : hci_csr

// File: hw/hci_pkg.sv
/* HCI front end shared definitions */
package hci_pkg;

  localparam int unsigned CsrAddrW = 12;
  localparam int unsigned CsrDataW = 32;
  localparam int unsigned CmdDataW = 64;  // Two DWORDs
  localparam int unsigned ThldW = 8;
  localparam int unsigned DynAddrW = 7;

  // Register map, byte addresses
  localparam logic [CsrAddrW-1:0] REG_RESET_CONTROL = 12'h010;
  localparam logic [CsrAddrW-1:0] REG_COMMAND_PORT = 12'h100;
  localparam logic [CsrAddrW-1:0] REG_RESPONSE_PORT = 12'h104;
  localparam logic [CsrAddrW-1:0] REG_QUEUE_THLD_CTRL = 12'h110;
  localparam logic [CsrAddrW-1:0] REG_QUEUE_STATUS = 12'h114;
  localparam logic [CsrAddrW-1:0] REG_DEVICE_ADDR = 12'h184;
  localparam logic [CsrAddrW-1:0] REG_VIRT_DEVICE_ADDR = 12'h188;

  // Field positions
  localparam int unsigned CMD_QUEUE_RST_BIT = 1;
  localparam int unsigned RESP_QUEUE_RST_BIT = 2;
  localparam int unsigned CMD_THLD_LSB = 0;
  localparam int unsigned RESP_THLD_LSB = 8;
  localparam int unsigned STAT_CMD_LSB = 0;  // empty, full, trig
  localparam int unsigned STAT_RESP_LSB = 3;
  localparam int unsigned ADDR_VALID_BIT = 31;
  localparam int unsigned ADDR_LSB = 16;

  typedef struct packed {
    logic                req;
    logic                is_wr;
    logic [CsrAddrW-1:0] addr;
    logic [CsrDataW-1:0] wdata;
  } csr_req_t;

  typedef struct packed {
    logic                rd_ack;
    logic                rd_err;
    logic                wr_ack;
    logic                wr_err;
    logic [CsrDataW-1:0] rd_data;
  } csr_rsp_t;

  typedef struct packed {
    logic full;
    logic empty;
    logic trig;
  } queue_stat_t;

  typedef struct packed {
    logic                valid;
    logic [DynAddrW-1:0] addr;
  } dyn_addr_t;

  // Address events from the bus controller
  typedef struct packed {
    logic                set_dasa;
    logic [DynAddrW-1:0] dasa;
    logic                dasa_virtual;
    logic                rstdaa;
    logic                set_newda;
    logic                set_newda_virtual;
    logic [DynAddrW-1:0] newda;
  } addr_evt_t;

endpackage : hci_pkg

// File: hw/hci_queue.sv
/* HCI queue with threshold trigger */
`timescale 1ns/1ps

module hci_queue #(
  parameter int unsigned DataW = 32,
  parameter int unsigned Depth = 8,
  parameter bit ThldOnFree = 1'b0,  // Trigger on free entries, else on stored
  localparam int unsigned DepthW = $clog2(Depth + 1),
  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      push_i,
  input  logic [DataW-1:0]          wdata_i,
  input  logic                      pop_i,
  output logic [DataW-1:0]          rdata_o,
  input  logic                      flush_i,
  output logic                      flush_done_o,
  input  logic [hci_pkg::ThldW-1:0] thld_i,
  output hci_pkg::queue_stat_t      stat_o,
  output logic [DepthW-1:0]         depth_o
);

  logic [DataW-1:0] mem [Depth];
  logic [PtrW-1:0] wptr_q, rptr_q;
  logic [DepthW-1:0] cnt_q;
  logic full, empty;
  logic do_push, do_pop;
  logic [hci_pkg::ThldW-1:0] thld_eff;
  logic [31:0] level;

  assign full = (cnt_q == DepthW'(Depth));
  assign empty = (cnt_q == '0);
  assign do_push = push_i && !full;  // Overflow dropped
  assign do_pop = pop_i && !empty;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q <= '0;
      rptr_q <= '0;
      cnt_q <= '0;
    end else if (flush_i) begin
      wptr_q <= '0;
      rptr_q <= '0;
      cnt_q <= '0;
    end else begin
      if (do_push) begin
        wptr_q <= (wptr_q == PtrW'(Depth - 1)) ? '0 : wptr_q + 1'b1;
      end
      if (do_pop) begin
        rptr_q <= (rptr_q == PtrW'(Depth - 1)) ? '0 : rptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (do_pop && !do_push) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push && !flush_i) begin
      mem[wptr_q] <= wdata_i;
    end
  end

  assign rdata_o = mem[rptr_q];  // Head entry, fall-through

  // Flush takes effect on the same edge
  assign flush_done_o = flush_i;

  // Threshold of 0 behaves as 1
  assign thld_eff = (thld_i == '0) ? hci_pkg::ThldW'(1) : thld_i;
  assign level = ThldOnFree ? (32'(Depth) - 32'(cnt_q)) : 32'(cnt_q);

  assign stat_o.full = full;
  assign stat_o.empty = empty;
  assign stat_o.trig = (level >= 32'(thld_eff));
  assign depth_o = cnt_q;

endmodule : hci_queue

// File: hw/hci_top.sv
/* HCI front end top */
`timescale 1ns/1ps

module hci_top #(
  parameter int unsigned CmdDepth = 8,
  parameter int unsigned RespDepth = 8,
  localparam int unsigned CmdDepthW = $clog2(CmdDepth + 1),
  localparam int unsigned RespDepthW = $clog2(RespDepth + 1)
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  hci_pkg::csr_req_t            csr_req_i,
  output hci_pkg::csr_rsp_t            csr_rsp_o,
  output logic                         cmd_rvalid_o,
  input  logic                         cmd_rready_i,
  output logic [hci_pkg::CmdDataW-1:0] cmd_rdata_o,
  output logic [CmdDepthW-1:0]         cmd_depth_o,
  input  logic                         resp_wvalid_i,
  output logic                         resp_wready_o,
  input  logic [hci_pkg::CsrDataW-1:0] resp_wdata_i,
  output logic [RespDepthW-1:0]        resp_depth_o,
  input  hci_pkg::addr_evt_t           addr_evt_i
);

  import hci_pkg::*;

  queue_stat_t cmd_stat, resp_stat;
  dyn_addr_t dev_addr, virt_addr;
  logic cmd_push, resp_pop;
  logic [CmdDataW-1:0] cmd_wdata;
  logic [CsrDataW-1:0] resp_rdata;
  logic cmd_flush, resp_flush;
  logic cmd_flush_done, resp_flush_done;
  logic [ThldW-1:0] cmd_thld, resp_thld;

  assign cmd_rvalid_o = !cmd_stat.empty;
  assign resp_wready_o = !resp_stat.full;

  hci_csr u_csr (
    .clk_i,
    .rst_ni,
    .csr_req_i,
    .csr_rsp_o,
    .cmd_stat_i       (cmd_stat),
    .resp_stat_i      (resp_stat),
    .resp_data_i      (resp_rdata),
    .cmd_flush_done_i (cmd_flush_done),
    .resp_flush_done_i(resp_flush_done),
    .dev_addr_i       (dev_addr),
    .virt_addr_i      (virt_addr),
    .cmd_push_o       (cmd_push),
    .cmd_data_o       (cmd_wdata),
    .resp_pop_o       (resp_pop),
    .cmd_flush_o      (cmd_flush),
    .resp_flush_o     (resp_flush),
    .cmd_thld_o       (cmd_thld),
    .resp_thld_o      (resp_thld)
  );

  // Threshold counts free entries
  hci_queue #(
    .DataW     (CmdDataW),
    .Depth     (CmdDepth),
    .ThldOnFree(1'b1)
  ) cmd_queue (
    .clk_i,
    .rst_ni,
    .push_i      (cmd_push),
    .wdata_i     (cmd_wdata),
    .pop_i       (cmd_rready_i),
    .rdata_o     (cmd_rdata_o),
    .flush_i     (cmd_flush),
    .flush_done_o(cmd_flush_done),
    .thld_i      (cmd_thld),
    .stat_o      (cmd_stat),
    .depth_o     (cmd_depth_o)
  );

  hci_queue #(
    .DataW     (CsrDataW),
    .Depth     (RespDepth),
    .ThldOnFree(1'b0)
  ) resp_queue (
    .clk_i,
    .rst_ni,
    .push_i      (resp_wvalid_i),
    .wdata_i     (resp_wdata_i),
    .pop_i       (resp_pop),
    .rdata_o     (resp_rdata),
    .flush_i     (resp_flush),
    .flush_done_o(resp_flush_done),
    .thld_i      (resp_thld),
    .stat_o      (resp_stat),
    .depth_o     (resp_depth_o)
  );

  hci_addr_ctrl u_addr_ctrl (
    .clk_i,
    .rst_ni,
    .addr_evt_i,
    .dev_addr_o (dev_addr),
    .virt_addr_o(virt_addr)
  );

endmodule : hci_top

// File: verification/hci_top_props.sv
/* HCI front end assertions */
`timescale 1ns/1ps

module hci_top_props (
  input logic              clk_i,
  input logic              rst_ni,
  input hci_pkg::csr_req_t csr_req_i,
  input hci_pkg::csr_rsp_t csr_rsp_i,
  input logic              cmd_rvalid_i,
  input logic              cmd_push_i,
  input logic              cmd_flush_i,
  input logic              resp_flush_i
);

  import hci_pkg::*;

  int unsigned assert_fail_cnt = 0;
  logic rst_ctrl_wr;

  assign rst_ctrl_wr = csr_req_i.req && csr_req_i.is_wr && (csr_req_i.addr == REG_RESET_CONTROL);

  rd_ack_follows_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (csr_req_i.req && !csr_req_i.is_wr) |=> csr_rsp_i.rd_ack)
    else begin
      assert_fail_cnt++;
      $error("read request not acknowledged in the next cycle");
    end

  wr_ack_follows_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (csr_req_i.req && csr_req_i.is_wr) |=> csr_rsp_i.wr_ack)
    else begin
      assert_fail_cnt++;
      $error("write request not acknowledged in the next cycle");
    end

  acks_exclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(csr_rsp_i.rd_ack && csr_rsp_i.wr_ack))
    else begin
      assert_fail_cnt++;
      $error("read and write acknowledge high together");
    end

  // Empty queue turns valid only through a push
  cmd_valid_after_push: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(cmd_rvalid_i) |-> $past(cmd_push_i))
    else begin
      assert_fail_cnt++;
      $error("command valid rose without a push into the empty queue");
    end

  cmd_rst_self_clears: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (rst_ctrl_wr && csr_req_i.wdata[CMD_QUEUE_RST_BIT]) |=> cmd_flush_i ##1 !cmd_flush_i)
    else begin
      assert_fail_cnt++;
      $error("command queue reset bit did not clear after two cycles");
    end

  resp_rst_self_clears: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (rst_ctrl_wr && csr_req_i.wdata[RESP_QUEUE_RST_BIT]) |=> resp_flush_i ##1 !resp_flush_i)
    else begin
      assert_fail_cnt++;
      $error("response queue reset bit did not clear after two cycles");
    end

endmodule : hci_top_props

bind hci_top hci_top_props u_props (
  .clk_i,
  .rst_ni,
  .csr_req_i,
  .csr_rsp_i   (csr_rsp_o),
  .cmd_rvalid_i(cmd_rvalid_o),
  .cmd_push_i  (cmd_push),
  .cmd_flush_i (cmd_flush),
  .resp_flush_i(resp_flush)
);

// File: verification/tb_hci_top.sv
/* HCI front end testbench */
`timescale 1ns/1ps

module tb_hci_top;

  import hci_pkg::*;

  localparam int unsigned CmdDepth = 8;
  localparam int unsigned RespDepth = 8;
  localparam int unsigned CmdDepthW = $clog2(CmdDepth + 1);
  localparam int unsigned RespDepthW = $clog2(RespDepth + 1);
  localparam int unsigned ClkPeriod = 8;
  localparam int unsigned NumTests = 6;
  localparam int unsigned CyclesPerTest = 300;
  localparam int unsigned WaitLimit = 20;

  logic clk = 1'b0;
  logic rst_n;
  csr_req_t csr_req;
  csr_rsp_t csr_rsp;
  logic cmd_rvalid, cmd_rready;
  logic [CmdDataW-1:0] cmd_rdata;
  logic [CmdDepthW-1:0] cmd_depth;
  logic [RespDepthW-1:0] resp_depth;
  logic resp_wvalid, resp_wready;
  logic [CsrDataW-1:0] resp_wdata;
  addr_evt_t addr_evt;
  logic [31:0] lcg_state = 32'd20435;

  always #(ClkPeriod / 2) clk = ~clk;

  hci_top #(
    .CmdDepth (CmdDepth),
    .RespDepth(RespDepth)
  ) uut (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .csr_req_i    (csr_req),
    .csr_rsp_o    (csr_rsp),
    .cmd_rvalid_o (cmd_rvalid),
    .cmd_rready_i (cmd_rready),
    .cmd_rdata_o  (cmd_rdata),
    .cmd_depth_o  (cmd_depth),
    .resp_wvalid_i(resp_wvalid),
    .resp_wready_o(resp_wready),
    .resp_wdata_i (resp_wdata),
    .resp_depth_o (resp_depth),
    .addr_evt_i   (addr_evt)
  );

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
      report_failure($sformatf("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
      report_failure($sformatf("MISMATCH %s: got 0x%08h expected 0x%08h", name, got, exp));
  endtask

  task automatic check_cmd(input string name, input logic [CmdDataW-1:0] got,
                           input logic [CmdDataW-1:0] exp);
    if (got !== exp)
      report_failure($sformatf("MISMATCH %s: got 0x%016h expected 0x%016h", name, got, exp));
  endtask

  task automatic check_stat(input string name, input queue_stat_t got, input queue_stat_t exp);
    if (got !== exp)
      report_failure($sformatf("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_addr(input string name, input dyn_addr_t got, input dyn_addr_t exp);
    if (got !== exp)
      report_failure($sformatf("MISMATCH %s: got 0x%02h expected 0x%02h", name, got, exp));
  endtask

  // Called on a falling edge, ack is due one cycle later
  task automatic csr_write(input logic [CsrAddrW-1:0] addr, input logic [31:0] data,
                           output logic err);
    csr_req = '{req: 1'b1, is_wr: 1'b1, addr: addr, wdata: data};
    @(negedge clk);
    csr_req.req = 1'b0;
    if (!csr_rsp.wr_ack) report_failure($sformatf("no write acknowledge for address 0x%03h", addr));
    err = csr_rsp.wr_err;
  endtask

  task automatic csr_read(input logic [CsrAddrW-1:0] addr, output logic [31:0] data,
                          output logic err);
    csr_req = '{req: 1'b1, is_wr: 1'b0, addr: addr, wdata: '0};
    @(negedge clk);
    csr_req.req = 1'b0;
    if (!csr_rsp.rd_ack) report_failure($sformatf("no read acknowledge for address 0x%03h", addr));
    data = csr_rsp.rd_data;
    err = csr_rsp.rd_err;
  endtask

  task automatic write_ok(input logic [CsrAddrW-1:0] addr, input logic [31:0] data);
    logic err;
    csr_write(addr, data, err);
    check_flag($sformatf("wr_err at 0x%03h", addr), err, 1'b0);
  endtask

  task automatic read_ok(input logic [CsrAddrW-1:0] addr, output logic [31:0] data);
    logic err;
    csr_read(addr, data, err);
    check_flag($sformatf("rd_err at 0x%03h", addr), err, 1'b0);
  endtask

  task automatic push_cmd(input logic [31:0] lo, input logic [31:0] hi);
    write_ok(REG_COMMAND_PORT, lo);
    write_ok(REG_COMMAND_PORT, hi);
  endtask

  task automatic pop_cmd(input int unsigned idle, output logic [CmdDataW-1:0] data);
    int unsigned waited;
    repeat (idle) @(negedge clk);  // Ready held low
    waited = 0;
    while (!cmd_rvalid) begin
      if (waited == WaitLimit) report_failure("command queue never presented a command");
      @(negedge clk);
      waited++;
    end
    data = cmd_rdata;
    cmd_rready = 1'b1;
    @(negedge clk);
    cmd_rready = 1'b0;
  endtask

  task automatic push_resp(input logic [31:0] data);
    int unsigned waited;
    waited = 0;
    while (!resp_wready) begin
      if (waited == WaitLimit) report_failure("response queue never became ready");
      @(negedge clk);
      waited++;
    end
    resp_wvalid = 1'b1;
    resp_wdata = data;
    @(negedge clk);
    resp_wvalid = 1'b0;
  endtask

  // Expected trigger from free space (cmd) and occupancy (resp)
  task automatic expect_queue_status(input int unsigned cmd_cnt, input int unsigned resp_cnt,
                                     input logic [ThldW-1:0] cmd_thld,
                                     input logic [ThldW-1:0] resp_thld);
    logic [31:0] word;
    int unsigned cmd_lim, resp_lim;
    queue_stat_t got, exp;
    cmd_lim = (cmd_thld == 0) ? 1 : cmd_thld;
    resp_lim = (resp_thld == 0) ? 1 : resp_thld;
    read_ok(REG_QUEUE_STATUS, word);
    check_word("QUEUE_STATUS reserved", word & 32'hffff_ffc0, 32'h0);
    got = queue_stat_t'{full: word[1], empty: word[0], trig: word[2]};
    exp = queue_stat_t'{full: cmd_cnt == CmdDepth, empty: cmd_cnt == 0,
                        trig: (CmdDepth - cmd_cnt) >= cmd_lim};
    check_stat("QUEUE_STATUS cmd", got, exp);
    got = queue_stat_t'{full: word[4], empty: word[3], trig: word[5]};
    exp = queue_stat_t'{full: resp_cnt == RespDepth, empty: resp_cnt == 0,
                        trig: resp_cnt >= resp_lim};
    check_stat("QUEUE_STATUS resp", got, exp);
  endtask

  task automatic reset_dut();
    rst_n = 1'b0;
    csr_req = '0;
    cmd_rready = 1'b0;
    resp_wvalid = 1'b0;
    resp_wdata = '0;
    addr_evt = '0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    check_word("csr_rsp_o flags",
               32'({csr_rsp.rd_ack, csr_rsp.rd_err, csr_rsp.wr_ack, csr_rsp.wr_err}), 32'h0);
    check_flag("cmd_rvalid_o", cmd_rvalid, 1'b0);
    check_flag("resp_wready_o", resp_wready, 1'b1);
  endtask

  task automatic test_cmd_path();
    logic [CmdDataW-1:0] expected[$];
    logic [CmdDataW-1:0] cmd;
    logic [31:0] lo, hi;
    logic err;
    for (int i = 0; i < CmdDepth; i++) begin
      lo = next_rand();
      hi = next_rand();
      push_cmd(lo, hi);
      expected.push_back({hi, lo});
      check_flag("cmd_rvalid_o", cmd_rvalid, 1'b1);
    end
    check_word("cmd_depth_o", 32'(cmd_depth), CmdDepth);
    // Second DWORD into a full queue
    csr_write(REG_COMMAND_PORT, next_rand(), err);
    check_flag("wr_err low DWORD", err, 1'b0);
    csr_write(REG_COMMAND_PORT, next_rand(), err);
    check_flag("wr_err high DWORD", err, 1'b1);
    check_word("cmd_depth_o", 32'(cmd_depth), CmdDepth);
    while (expected.size() > 0) begin
      pop_cmd(next_rand() % 4, cmd);
      check_cmd("cmd_rdata_o", cmd, expected.pop_front());
    end
    check_flag("cmd_rvalid_o", cmd_rvalid, 1'b0);
  endtask

  task automatic test_resp_path();
    logic [31:0] expected[$];
    logic [31:0] data;
    logic err;
    for (int i = 0; i < RespDepth; i++) begin
      data = next_rand();
      push_resp(data);
      expected.push_back(data);
    end
    check_flag("resp_wready_o", resp_wready, 1'b0);
    resp_wvalid = 1'b1;  // Dropped while full
    resp_wdata = next_rand();
    @(negedge clk);
    resp_wvalid = 1'b0;
    check_word("resp_depth_o", 32'(resp_depth), RespDepth);
    while (expected.size() > 0) begin
      read_ok(REG_RESPONSE_PORT, data);
      check_word("RESPONSE_PORT", data, expected.pop_front());
    end
    check_flag("resp_wready_o", resp_wready, 1'b1);
    csr_read(REG_RESPONSE_PORT, data, err);
    check_flag("rd_err on empty queue", err, 1'b1);
    check_word("RESPONSE_PORT on empty queue", data, 32'h0);
  endtask

  task automatic test_thresholds();
    logic [ThldW-1:0] cmd_thld, resp_thld;
    logic [CmdDataW-1:0] cmd;
    logic [31:0] word;
    cmd_thld = 8'd3;
    resp_thld = 8'd5;
    write_ok(REG_QUEUE_THLD_CTRL, {16'h0, resp_thld, cmd_thld});
    read_ok(REG_QUEUE_THLD_CTRL, word);
    check_word("QUEUE_THLD_CTRL", word, {16'h0, resp_thld, cmd_thld});
    for (int i = 0; i <= CmdDepth; i++) begin
      expect_queue_status(i, i, cmd_thld, resp_thld);
      if (i < CmdDepth) begin
        push_cmd(next_rand(), next_rand());
        push_resp(next_rand());
      end
    end
    for (int i = CmdDepth; i > 0; i--) begin
      pop_cmd(0, cmd);
      read_ok(REG_RESPONSE_PORT, word);
      expect_queue_status(i - 1, i - 1, cmd_thld, resp_thld);
    end
    write_ok(REG_QUEUE_THLD_CTRL, 32'h0);  // Zero acts as one
    expect_queue_status(0, 0, 8'd0, 8'd0);
  endtask

  task automatic test_soft_reset();
    logic [CmdDataW-1:0] cmd;
    logic [31:0] word;
    for (int i = 0; i < 3; i++) begin
      push_cmd(next_rand(), next_rand());
      push_resp(next_rand());
    end
    check_word("cmd_depth_o", 32'(cmd_depth), 32'd3);
    check_word("resp_depth_o", 32'(resp_depth), 32'd3);
    write_ok(REG_RESET_CONTROL, 32'h6);
    read_ok(REG_RESET_CONTROL, word);  // Sampled one cycle after the write
    check_word("RESET_CONTROL while set", word, 32'h6);
    check_word("cmd_depth_o after flush", 32'(cmd_depth), 32'd0);
    check_word("resp_depth_o after flush", 32'(resp_depth), 32'd0);
    check_flag("cmd_rvalid_o after flush", cmd_rvalid, 1'b0);
    read_ok(REG_RESET_CONTROL, word);
    check_word("RESET_CONTROL after flush", word, 32'h0);
    expect_queue_status(0, 0, 8'd0, 8'd0);
    // Queue still usable afterwards
    push_cmd(32'h1111_2222, 32'h3333_4444);
    pop_cmd(1, cmd);
    check_cmd("cmd_rdata_o after flush", cmd, 64'h3333_4444_1111_2222);
  endtask

  task automatic addr_step(input addr_evt_t evt, input dyn_addr_t exp_dev,
                           input dyn_addr_t exp_virt);
    logic [31:0] word;
    dyn_addr_t got;
    addr_evt = evt;
    @(negedge clk);
    addr_evt = '0;
    read_ok(REG_DEVICE_ADDR, word);
    got = dyn_addr_t'{valid: word[31], addr: word[22:16]};
    check_addr("DEVICE_ADDR", got, exp_dev);
    check_word("DEVICE_ADDR reserved", word & 32'h7f80_ffff, 32'h0);
    read_ok(REG_VIRT_DEVICE_ADDR, word);
    got = dyn_addr_t'{valid: word[31], addr: word[22:16]};
    check_addr("VIRT_DEVICE_ADDR", got, exp_virt);
    check_word("VIRT_DEVICE_ADDR reserved", word & 32'h7f80_ffff, 32'h0);
  endtask

  task automatic test_addr_events();
    addr_evt_t evt;
    evt = '0;
    addr_step(evt, dyn_addr_t'{1'b0, 7'h00}, dyn_addr_t'{1'b0, 7'h00});
    evt.set_dasa = 1'b1;
    evt.dasa = 7'h12;
    addr_step(evt, dyn_addr_t'{1'b1, 7'h12}, dyn_addr_t'{1'b0, 7'h00});
    evt.dasa_virtual = 1'b1;
    evt.dasa = 7'h34;
    addr_step(evt, dyn_addr_t'{1'b1, 7'h12}, dyn_addr_t'{1'b1, 7'h34});
    evt = '0;
    evt.set_newda = 1'b1;
    evt.set_newda_virtual = 1'b1;
    evt.newda = 7'h56;
    addr_step(evt, dyn_addr_t'{1'b1, 7'h56}, dyn_addr_t'{1'b1, 7'h56});
    // SETDASA wins, SETNEWDA ignored
    evt = '0;
    evt.set_dasa = 1'b1;
    evt.dasa = 7'h21;
    evt.set_newda_virtual = 1'b1;
    evt.newda = 7'h77;
    addr_step(evt, dyn_addr_t'{1'b1, 7'h21}, dyn_addr_t'{1'b1, 7'h56});
    evt = '0;
    evt.rstdaa = 1'b1;
    evt.set_newda = 1'b1;
    evt.newda = 7'h3c;
    addr_step(evt, dyn_addr_t'{1'b0, 7'h00}, dyn_addr_t'{1'b1, 7'h56});
    evt = '0;
    evt.rstdaa = 1'b1;
    evt.dasa_virtual = 1'b1;
    addr_step(evt, dyn_addr_t'{1'b0, 7'h00}, dyn_addr_t'{1'b0, 7'h00});
    evt = '0;
    evt.set_newda_virtual = 1'b1;
    evt.newda = 7'h0a;
    addr_step(evt, dyn_addr_t'{1'b0, 7'h00}, dyn_addr_t'{1'b1, 7'h0a});
  endtask

  task automatic test_unmapped();
    logic [31:0] data;
    logic err;
    csr_read(12'h020, data, err);
    check_flag("rd_err unmapped", err, 1'b1);
    check_word("rd_data unmapped", data, 32'h0);
    csr_write(12'h3fc, next_rand(), err);
    check_flag("wr_err unmapped", err, 1'b1);
    csr_write(12'h108, next_rand(), err);
    check_flag("wr_err unmapped gap", err, 1'b1);
  endtask

  initial begin
    reset_dut();
    test_cmd_path();
    test_resp_path();
    test_thresholds();
    test_soft_reset();
    test_addr_events();
    test_unmapped();
    repeat (2) @(negedge clk);
    $display("ALL CHECKS PASSED");
    $finish;
  end

  // Stop at the first bound assertion failure
  initial begin
    wait (uut.u_props.assert_fail_cnt != 0);
    report_failure("a bound assertion on the DUT failed");
  end

  // Watchdog
  initial begin
    #(NumTests * CyclesPerTest * ClkPeriod);
    $display("CHECKS FAILED");
    $fatal(1, "watchdog expired after %0d cycles", NumTests * CyclesPerTest);
  end

endmodule : tb_hci_top
